/* filelist.f */
rtl/pulpemu_pkg.sv
rtl/apb_if.sv
rtl/pulpemu_apb_demux.sv
rtl/pulpemu_spi_slave.sv
rtl/pulpemu_uart.sv
rtl/pulpemu.sv
tb/tb_pulpemu.sv

/* rtl/apb_if.sv */
`timescale 1ns/1ps

interface apb_if;
  import pulpemu_pkg::*;

  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic [APB_DATA_WIDTH-1:0] pwdata;
  logic [APB_DATA_WIDTH-1:0] prdata;
  logic                      pready;
  logic                      pslverr;

  // request side
  modport master (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  // response side
  modport slave (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

/* rtl/pulpemu.sv */
`timescale 1ns/1ps

module pulpemu (
  input  logic                                  zynq_clk_i,
  input  logic                                  rst_i,
  input  logic                                  apb_psel_i,
  input  logic                                  apb_penable_i,
  input  logic                                  apb_pwrite_i,
  input  logic [pulpemu_pkg::APB_ADDR_WIDTH-1:0] apb_paddr_i,
  input  logic [pulpemu_pkg::APB_DATA_WIDTH-1:0] apb_pwdata_i,
  output logic [pulpemu_pkg::APB_DATA_WIDTH-1:0] apb_prdata_o,
  output logic                                  apb_pready_o,
  output logic                                  apb_pslverr_o,
  output logic                                  spi_sck_o,
  output logic                                  spi_csn_o,
  output logic                                  spi_sdo_o,
  input  logic                                  spi_sdi_i,
  input  logic                                  uart_rx_i
);

  apb_if host_bus ();
  apb_if spi_bus ();
  apb_if uart_bus ();

  // zynq side port into the bus bundle
  assign host_bus.psel    = apb_psel_i;
  assign host_bus.penable = apb_penable_i;
  assign host_bus.pwrite  = apb_pwrite_i;
  assign host_bus.paddr   = apb_paddr_i;
  assign host_bus.pwdata  = apb_pwdata_i;
  assign apb_prdata_o     = host_bus.prdata;
  assign apb_pready_o     = host_bus.pready;
  assign apb_pslverr_o    = host_bus.pslverr;

  pulpemu_apb_demux pulpemu_apb_demux_i (
    .zynq_clk_i ( zynq_clk_i ),
    .rst_i      ( rst_i      ),
    .host       ( host_bus   ),
    .spi        ( spi_bus    ),
    .uart       ( uart_bus   )
  );

  pulpemu_spi_slave pulpemu_spi_slave_i (
    .zynq_clk_i ( zynq_clk_i ),
    .rst_i      ( rst_i      ),
    .apb        ( spi_bus    ),
    .sck_o      ( spi_sck_o  ),
    .csn_o      ( spi_csn_o  ),
    .sdo_o      ( spi_sdo_o  ),
    .sdi_i      ( spi_sdi_i  )
  );

  // stdout capture only
  pulpemu_uart pulpemu_uart_i (
    .zynq_clk_i ( zynq_clk_i ),
    .rst_i      ( rst_i      ),
    .apb        ( uart_bus   ),
    .rx_i       ( uart_rx_i  )
  );

endmodule

/* rtl/pulpemu_apb_demux.sv */
`timescale 1ns/1ps

module pulpemu_apb_demux (
  input  logic  zynq_clk_i,
  input  logic  rst_i,
  apb_if.slave  host,
  apb_if.master spi,
  apb_if.master uart
);
  import pulpemu_pkg::*;

  logic [REGION_WIDTH-1:0] region;
  logic                    sel_spi;
  logic                    sel_uart;

  assign region   = host.paddr[REGION_MSB:REGION_LSB];
  assign sel_spi  = (region == REGION_SPI);
  assign sel_uart = (region == REGION_UART);

  // request fan-out, only psel is steered
  assign spi.psel     = host.psel & sel_spi;
  assign spi.penable  = host.penable;
  assign spi.pwrite   = host.pwrite;
  assign spi.paddr    = host.paddr;
  assign spi.pwdata   = host.pwdata;

  assign uart.psel    = host.psel & sel_uart;
  assign uart.penable = host.penable;
  assign uart.pwrite  = host.pwrite;
  assign uart.paddr   = host.paddr;
  assign uart.pwdata  = host.pwdata;

  always_comb begin
    // unmapped region answers itself with an error
    host.prdata  = '0;
    host.pready  = 1'b1;
    host.pslverr = host.psel;
    if (sel_spi) begin
      host.prdata  = spi.prdata;
      host.pready  = spi.pready;
      host.pslverr = spi.pslverr;
    end else if (sel_uart) begin
      host.prdata  = uart.prdata;
      host.pready  = uart.pready;
      host.pslverr = uart.pslverr;
    end
  end

  a_one_hot_sel: assert property (
    @(posedge zynq_clk_i) disable iff (rst_i) !(spi.psel && uart.psel)
  );

endmodule

/* rtl/pulpemu_pkg.sv */
package pulpemu_pkg;

  // host APB port
  localparam int APB_ADDR_WIDTH = 32;
  localparam int APB_DATA_WIDTH = 32;

  // address map, one region per peripheral
  localparam int REGION_LSB   = 8;
  localparam int REGION_MSB   = 11;
  localparam int REGION_WIDTH = REGION_MSB - REGION_LSB + 1;

  localparam logic [REGION_WIDTH-1:0] REGION_SPI  = 4'd0;
  localparam logic [REGION_WIDTH-1:0] REGION_UART = 4'd1;

  // register offsets inside a region
  localparam logic [REGION_LSB-1:0] SPI_TXDATA_OFS  = 8'h00;
  localparam logic [REGION_LSB-1:0] SPI_RXDATA_OFS  = 8'h04;
  localparam logic [REGION_LSB-1:0] SPI_STATUS_OFS  = 8'h08;
  localparam logic [REGION_LSB-1:0] UART_DATA_OFS   = 8'h00;
  localparam logic [REGION_LSB-1:0] UART_STATUS_OFS = 8'h04;

  // spi timing
  localparam int SPI_HALF_PERIOD    = 4;  // zynq_clk cycles per sck half
  localparam int SPI_FRAME_BITS     = 8;
  localparam int SPI_HALF_CNT_WIDTH = $clog2(SPI_HALF_PERIOD);
  localparam int SPI_BIT_CNT_WIDTH  = $clog2(SPI_FRAME_BITS);

  // uart receiver, 8N1
  localparam int UART_CLKS_PER_BIT   = 8;
  localparam int UART_DATA_BITS      = 8;
  localparam int UART_FIFO_DEPTH     = 8;
  localparam int UART_TICK_WIDTH     = $clog2(UART_CLKS_PER_BIT);
  localparam int UART_BIT_CNT_WIDTH  = $clog2(UART_DATA_BITS);
  localparam int UART_PTR_WIDTH      = $clog2(UART_FIFO_DEPTH);
  localparam int UART_CNT_WIDTH      = $clog2(UART_FIFO_DEPTH + 1);

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_DONE
  } spi_state_e;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

/* rtl/pulpemu_spi_slave.sv */
`timescale 1ns/1ps

module pulpemu_spi_slave (
  input  logic zynq_clk_i,
  input  logic rst_i,
  apb_if.slave apb,
  output logic sck_o,
  output logic csn_o,
  output logic sdo_o,
  input  logic sdi_i
);
  import pulpemu_pkg::*;

  spi_state_e                    state_q;
  logic [SPI_HALF_CNT_WIDTH-1:0] half_cnt_q;
  logic [SPI_BIT_CNT_WIDTH-1:0]  bit_cnt_q;
  logic [SPI_FRAME_BITS-1:0]     shift_q;   // tx out at msb, rx in at lsb
  logic [SPI_FRAME_BITS-1:0]     rx_data_q;
  logic                          sck_q;
  logic                          csn_q;
  logic                          sdi_q;
  logic [REGION_LSB-1:0]         offset;
  logic                          busy;
  logic                          start;
  logic                          half_end;
  logic                          sck_rise;
  logic                          sck_fall;

  assign offset = apb.paddr[REGION_LSB-1:0];
  assign busy   = (state_q == SPI_SHIFT);

  // txdata write accepted only when no frame is running
  assign start = apb.psel & apb.penable & apb.pwrite &
                 (offset == SPI_TXDATA_OFS) & ~busy;

  assign half_end = busy && (half_cnt_q == SPI_HALF_CNT_WIDTH'(SPI_HALF_PERIOD - 1));
  assign sck_rise = half_end & ~sck_q;
  assign sck_fall = half_end & sck_q;

  always_ff @(posedge zynq_clk_i) begin
    if (rst_i) begin
      state_q    <= SPI_IDLE;
      half_cnt_q <= '0;
      bit_cnt_q  <= '0;
      sck_q      <= 1'b0;
      csn_q      <= 1'b1;
      rx_data_q  <= '0;
    end else begin
      case (state_q)
        SPI_SHIFT: begin
          if (half_end) begin
            half_cnt_q <= '0;
            sck_q      <= ~sck_q;
            if (sck_q) begin  // falling sck closes a bit
              if (bit_cnt_q == SPI_BIT_CNT_WIDTH'(SPI_FRAME_BITS - 1)) begin
                state_q <= SPI_DONE;
                csn_q   <= 1'b1;
              end else begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
              end
            end
          end else begin
            half_cnt_q <= half_cnt_q + 1'b1;
          end
        end
        default: begin
          if (state_q == SPI_DONE) begin
            rx_data_q <= shift_q;  // full frame received
          end
          if (start) begin
            state_q    <= SPI_SHIFT;
            csn_q      <= 1'b0;
            half_cnt_q <= '0;
            bit_cnt_q  <= '0;
            sck_q      <= 1'b0;
          end else begin
            state_q <= SPI_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge zynq_clk_i) begin
    if (start) begin
      shift_q <= apb.pwdata[SPI_FRAME_BITS-1:0];
    end else if (sck_fall) begin
      shift_q <= {shift_q[SPI_FRAME_BITS-2:0], sdi_q};
    end
    if (sck_rise) begin
      sdi_q <= sdi_i;  // mode 0 sample point
    end
  end

  assign sck_o = sck_q;
  assign csn_o = csn_q;
  assign sdo_o = shift_q[SPI_FRAME_BITS-1] & ~csn_q;

  assign apb.pready = 1'b1;

  always_comb begin
    apb.prdata  = '0;
    apb.pslverr = 1'b0;
    case (offset)
      SPI_TXDATA_OFS: apb.pslverr = apb.psel & apb.pwrite & busy;
      SPI_RXDATA_OFS: apb.prdata  = APB_DATA_WIDTH'(rx_data_q);
      SPI_STATUS_OFS: apb.prdata  = APB_DATA_WIDTH'(busy);
      default:        apb.pslverr = apb.psel;
    endcase
  end

  a_csn_only_in_shift: assert property (
    @(posedge zynq_clk_i) disable iff (rst_i) !csn_o |-> (state_q == SPI_SHIFT)
  );

  a_sck_idle_low: assert property (
    @(posedge zynq_clk_i) disable iff (rst_i) csn_o |-> !sck_o
  );

endmodule

/* rtl/pulpemu_uart.sv */
`timescale 1ns/1ps

module pulpemu_uart (
  input  logic zynq_clk_i,
  input  logic rst_i,
  apb_if.slave apb,
  input  logic rx_i
);
  import pulpemu_pkg::*;

  uart_state_e                   state_q;
  logic                          rx_meta_q;
  logic                          rx_sync_q;
  logic [UART_TICK_WIDTH-1:0]    tick_q;
  logic [UART_BIT_CNT_WIDTH-1:0] bit_q;
  logic [UART_DATA_BITS-1:0]     shreg_q;
  logic [UART_DATA_BITS-1:0]     mem_q [UART_FIFO_DEPTH];
  logic [UART_PTR_WIDTH-1:0]     wr_ptr_q;
  logic [UART_PTR_WIDTH-1:0]     rd_ptr_q;
  logic [UART_CNT_WIDTH-1:0]     count_q;
  logic                          ovf_q;
  logic [REGION_LSB-1:0]         offset;
  logic                          half_end;
  logic                          tick_end;
  logic                          rx_done;
  logic                          full;
  logic                          empty;
  logic                          push;
  logic                          pop;
  logic                          read_acc;
  logic                          stat_rd;

  assign half_end = (tick_q == UART_TICK_WIDTH'(UART_CLKS_PER_BIT / 2 - 1));
  assign tick_end = (tick_q == UART_TICK_WIDTH'(UART_CLKS_PER_BIT - 1));

  // byte complete at mid stop bit, framing must be valid
  assign rx_done = (state_q == UART_STOP) & tick_end & rx_sync_q;

  always_ff @(posedge zynq_clk_i) begin
    if (rst_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      state_q   <= UART_IDLE;
      tick_q    <= '0;
      bit_q     <= '0;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      case (state_q)
        UART_IDLE: begin
          tick_q <= '0;
          if (!rx_sync_q) begin
            state_q <= UART_START;
          end
        end
        UART_START: begin
          if (half_end) begin
            tick_q  <= '0;
            bit_q   <= '0;
            state_q <= rx_sync_q ? UART_IDLE : UART_DATA;  // glitch rejects
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
        UART_DATA: begin
          if (tick_end) begin
            tick_q <= '0;
            if (bit_q == UART_BIT_CNT_WIDTH'(UART_DATA_BITS - 1)) begin
              state_q <= UART_STOP;
            end else begin
              bit_q <= bit_q + 1'b1;
            end
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
        UART_STOP: begin
          if (tick_end) begin
            tick_q  <= '0;
            state_q <= UART_IDLE;
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
      endcase
    end
  end

  // lsb first
  always_ff @(posedge zynq_clk_i) begin
    if ((state_q == UART_DATA) && tick_end) begin
      shreg_q <= {rx_sync_q, shreg_q[UART_DATA_BITS-1:1]};
    end
    if (push) begin
      mem_q[wr_ptr_q] <= shreg_q;
    end
  end

  assign offset   = apb.paddr[REGION_LSB-1:0];
  assign read_acc = apb.psel & apb.penable & ~apb.pwrite;
  assign full     = (count_q == UART_CNT_WIDTH'(UART_FIFO_DEPTH));
  assign empty    = (count_q == '0);
  assign push     = rx_done & ~full;
  assign pop      = read_acc & (offset == UART_DATA_OFS) & ~empty;
  assign stat_rd  = read_acc & (offset == UART_STATUS_OFS);

  always_ff @(posedge zynq_clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ovf_q    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // a new drop wins over the clear
      if (rx_done && full) begin
        ovf_q <= 1'b1;
      end else if (stat_rd) begin
        ovf_q <= 1'b0;
      end
    end
  end

  assign apb.pready = 1'b1;

  always_comb begin
    apb.prdata  = '0;
    apb.pslverr = 1'b0;
    case (offset)
      UART_DATA_OFS: begin
        if (!empty) begin
          apb.prdata = APB_DATA_WIDTH'(mem_q[rd_ptr_q]);
        end
      end
      UART_STATUS_OFS: apb.prdata = APB_DATA_WIDTH'({ovf_q, ~empty});
      default:         apb.pslverr = apb.psel;
    endcase
  end

  a_count_in_range: assert property (
    @(posedge zynq_clk_i) disable iff (rst_i)
      count_q <= UART_CNT_WIDTH'(UART_FIFO_DEPTH)
  );

  // read pointer only moves away from a non-empty fifo
  a_no_pop_empty: assert property (
    @(posedge zynq_clk_i) disable iff (rst_i)
      $changed(rd_ptr_q) |-> $past(count_q != '0)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run tb_pulpemu with verilator, fail if the log reports a failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_pulpemu \
  -f filelist.f -o tb_pulpemu > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_pulpemu > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log

grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } \
  || { grep -q "Everything OK" sim.log && echo "PASS"; } \
  || { echo "FAIL"; exit 1; }

/* tb/tb_pulpemu.sv */
`timescale 1ns/1ps

module tb_pulpemu;
  import pulpemu_pkg::*;

  localparam int          CLK_PERIOD     = 8;
  localparam int          SAMPLE_DELAY   = 2;     // ns after the falling edge
  localparam int          TIMEOUT_CYCLES = 5000;  // roughly 4x the whole table
  localparam logic [31:0] RAND_SEED      = 32'hc8a1_26dc;
  localparam int          UART_BYTES     = 12;
  localparam logic [7:0]  SPI_BYTE_A     = 8'ha5;
  localparam logic [7:0]  SPI_BYTE_B     = 8'h3c;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_SPI_WAIT,
    OP_UART_SEND
  } op_e;

  typedef struct packed {
    op_e                       kind;
    logic [APB_ADDR_WIDTH-1:0] addr;
    logic [APB_DATA_WIDTH-1:0] data;
    logic [APB_DATA_WIDTH-1:0] exp_rdata;
    logic                      exp_err;
  } step_t;

  logic                      zynq_clk;
  logic                      rst;
  logic                      apb_psel;
  logic                      apb_penable;
  logic                      apb_pwrite;
  logic [APB_ADDR_WIDTH-1:0] apb_paddr;
  logic [APB_DATA_WIDTH-1:0] apb_pwdata;
  logic [APB_DATA_WIDTH-1:0] apb_prdata;
  logic                      apb_pready;
  logic                      apb_pslverr;
  logic                      spi_sck;
  logic                      spi_csn;
  logic                      spi_sdo;
  logic                      spi_sdi;
  logic                      uart_rx;

  step_t      steps[$];
  logic       sdo_bits[$];   // sdo_o seen at each sck rise
  logic       sck_seen;
  logic [7:0] rand_bytes [UART_BYTES];
  int         cycle_cnt = 0;
  int         err_cnt   = 0;
  int         step_cnt  = 0;

  pulpemu pulpemu_i (
    .zynq_clk_i    ( zynq_clk    ),
    .rst_i         ( rst         ),
    .apb_psel_i    ( apb_psel    ),
    .apb_penable_i ( apb_penable ),
    .apb_pwrite_i  ( apb_pwrite  ),
    .apb_paddr_i   ( apb_paddr   ),
    .apb_pwdata_i  ( apb_pwdata  ),
    .apb_prdata_o  ( apb_prdata  ),
    .apb_pready_o  ( apb_pready  ),
    .apb_pslverr_o ( apb_pslverr ),
    .spi_sck_o     ( spi_sck     ),
    .spi_csn_o     ( spi_csn     ),
    .spi_sdo_o     ( spi_sdo     ),
    .spi_sdi_i     ( spi_sdi     ),
    .uart_rx_i     ( uart_rx     )
  );

  initial begin
    zynq_clk = 1'b0;
    forever #(CLK_PERIOD / 2) zynq_clk = ~zynq_clk;
  end

  // spi device model answers each bit inverted
  always @(negedge zynq_clk) begin
    spi_sdi <= ~spi_sdo;
  end

  always @(negedge zynq_clk) begin
    if (spi_sck && !sck_seen) begin
      sdo_bits.push_back(spi_sdo);
    end
    sck_seen = spi_sck;
  end

  always @(posedge zynq_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("steps run: %0d, errors: %0d", step_cnt, err_cnt);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [APB_ADDR_WIDTH-1:0] reg_addr(input logic [REGION_WIDTH-1:0] region,
                                                         input logic [REGION_LSB-1:0] ofs);
    reg_addr = '0;
    reg_addr[REGION_MSB:REGION_LSB] = region;
    reg_addr[REGION_LSB-1:0]        = ofs;
  endfunction

  function automatic logic [APB_DATA_WIDTH-1:0] inverted(input logic [7:0] b);
    inverted      = '0;
    inverted[7:0] = ~b;  // loopback returns every bit flipped
  endfunction

  function automatic logic [APB_DATA_WIDTH-1:0] uart_status(input logic ovf, input logic avail);
    uart_status    = '0;
    uart_status[0] = avail;
    uart_status[1] = ovf;
  endfunction

  task automatic note_error(input string msg);
    err_cnt++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic add_step(input op_e kind, input logic [APB_ADDR_WIDTH-1:0] addr,
                          input logic [APB_DATA_WIDTH-1:0] data,
                          input logic [APB_DATA_WIDTH-1:0] exp_rdata, input logic exp_err);
    step_t st;
    st.kind      = kind;
    st.addr      = addr;
    st.data      = data;
    st.exp_rdata = exp_rdata;
    st.exp_err   = exp_err;
    steps.push_back(st);
  endtask

  // setup cycle, then one access cycle with no wait states
  task automatic apb_access(input logic is_write, input logic [APB_ADDR_WIDTH-1:0] addr,
                            input logic [APB_DATA_WIDTH-1:0] wdata,
                            output logic [APB_DATA_WIDTH-1:0] rdata, output logic err);
    @(negedge zynq_clk);
    apb_psel    = 1'b1;
    apb_penable = 1'b0;
    apb_pwrite  = is_write;
    apb_paddr   = addr;
    apb_pwdata  = wdata;
    @(negedge zynq_clk);
    apb_penable = 1'b1;
    #SAMPLE_DELAY;
    if (apb_pready !== 1'b1) begin
      note_error($sformatf("access 0x%03h pready %b in the access cycle, expected 1", addr,
                           apb_pready));
    end
    rdata = apb_prdata;
    err   = apb_pslverr;
    @(negedge zynq_clk);
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
  endtask

  task automatic hold_rx(input logic level);
    uart_rx = level;
    repeat (UART_CLKS_PER_BIT) @(negedge zynq_clk);
  endtask

  // 8N1 frame plus one idle bit
  task automatic uart_send(input logic [7:0] data);
    int i;
    @(negedge zynq_clk);
    hold_rx(1'b0);
    for (i = 0; i < 8; i++) begin
      hold_rx(data[i]);
    end
    hold_rx(1'b1);
    hold_rx(1'b1);
  endtask

  task automatic wait_spi_frame(input logic [7:0] sent);
    logic [APB_DATA_WIDTH-1:0] rdata;
    logic                      err;
    int                        i;
    rdata = 1;
    while (rdata[0]) begin
      apb_access(1'b0, reg_addr(REGION_SPI, SPI_STATUS_OFS), '0, rdata, err);
    end
    if (spi_csn !== 1'b1) begin
      note_error("csn_o still low after busy cleared");
    end
    if (sdo_bits.size() != SPI_FRAME_BITS) begin
      note_error($sformatf("%0d bits on sdo_o, expected %0d", sdo_bits.size(), SPI_FRAME_BITS));
    end else begin
      for (i = 0; i < SPI_FRAME_BITS; i++) begin
        if (sdo_bits[i] !== sent[SPI_FRAME_BITS-1-i]) begin
          note_error($sformatf("sdo_o bit %0d of 0x%02h is %0b", i, sent, sdo_bits[i]));
        end
      end
    end
    sdo_bits.delete();
  endtask

  task automatic run_steps();
    step_t                     st;
    logic [APB_DATA_WIDTH-1:0] rdata;
    logic                      err;
    foreach (steps[n]) begin
      st = steps[n];
      step_cnt++;
      case (st.kind)
        OP_WRITE: begin
          apb_access(1'b1, st.addr, st.data, rdata, err);
          if (err !== st.exp_err) begin
            note_error($sformatf("write 0x%03h pslverr %0b, expected %0b", st.addr, err,
                                 st.exp_err));
          end
        end
        OP_READ: begin
          apb_access(1'b0, st.addr, '0, rdata, err);
          if (rdata !== st.exp_rdata) begin
            note_error($sformatf("read 0x%03h gave 0x%0h, expected 0x%0h", st.addr, rdata,
                                 st.exp_rdata));
          end
          if (err !== st.exp_err) begin
            note_error($sformatf("read 0x%03h pslverr %0b, expected %0b", st.addr, err,
                                 st.exp_err));
          end
        end
        OP_SPI_WAIT:  wait_spi_frame(st.data[7:0]);
        OP_UART_SEND: uart_send(st.data[7:0]);
        default: ;
      endcase
    end
  endtask

  initial begin
    int i;
    void'($urandom(RAND_SEED));
    rst         = 1'b1;
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite  = 1'b0;
    apb_paddr   = '0;
    apb_pwdata  = '0;
    spi_sdi     = 1'b0;
    uart_rx     = 1'b1;  // line idles high
    sck_seen    = 1'b0;
    for (i = 0; i < UART_BYTES; i++) begin
      rand_bytes[i] = 8'($urandom);
    end

    // reset values
    add_step(OP_READ, reg_addr(REGION_SPI, SPI_STATUS_OFS), '0, '0, 1'b0);
    add_step(OP_READ, reg_addr(REGION_UART, UART_STATUS_OFS), '0, '0, 1'b0);
    add_step(OP_READ, reg_addr(REGION_SPI, SPI_RXDATA_OFS), '0, '0, 1'b0);
    // single frame
    add_step(OP_WRITE, reg_addr(REGION_SPI, SPI_TXDATA_OFS), {24'h0, SPI_BYTE_A}, '0, 1'b0);
    add_step(OP_SPI_WAIT, '0, {24'h0, SPI_BYTE_A}, '0, 1'b0);
    add_step(OP_READ, reg_addr(REGION_SPI, SPI_RXDATA_OFS), '0, inverted(SPI_BYTE_A), 1'b0);
    // second write lands while busy
    add_step(OP_WRITE, reg_addr(REGION_SPI, SPI_TXDATA_OFS), {24'h0, SPI_BYTE_B}, '0, 1'b0);
    add_step(OP_WRITE, reg_addr(REGION_SPI, SPI_TXDATA_OFS), 32'hff, '0, 1'b1);
    add_step(OP_SPI_WAIT, '0, {24'h0, SPI_BYTE_B}, '0, 1'b0);
    add_step(OP_READ, reg_addr(REGION_SPI, SPI_RXDATA_OFS), '0, inverted(SPI_BYTE_B), 1'b0);
    // three bytes then drain
    for (i = 0; i < 3; i++) begin
      add_step(OP_UART_SEND, '0, {24'h0, rand_bytes[i]}, '0, 1'b0);
    end
    add_step(OP_READ, reg_addr(REGION_UART, UART_STATUS_OFS), '0, uart_status(0, 1), 1'b0);
    for (i = 0; i < 3; i++) begin
      add_step(OP_READ, reg_addr(REGION_UART, UART_DATA_OFS), '0, {24'h0, rand_bytes[i]}, 1'b0);
    end
    add_step(OP_READ, reg_addr(REGION_UART, UART_STATUS_OFS), '0, uart_status(0, 0), 1'b0);
    // nine bytes into an eight deep fifo
    for (i = 3; i < 12; i++) begin
      add_step(OP_UART_SEND, '0, {24'h0, rand_bytes[i]}, '0, 1'b0);
    end
    add_step(OP_READ, reg_addr(REGION_UART, UART_STATUS_OFS), '0, uart_status(1, 1), 1'b0);
    for (i = 3; i < 11; i++) begin
      add_step(OP_READ, reg_addr(REGION_UART, UART_DATA_OFS), '0, {24'h0, rand_bytes[i]}, 1'b0);
    end
    add_step(OP_READ, reg_addr(REGION_UART, UART_STATUS_OFS), '0, uart_status(0, 0), 1'b0);
    add_step(OP_READ, reg_addr(REGION_UART, UART_DATA_OFS), '0, '0, 1'b0);
    // unmapped region and offsets
    add_step(OP_READ, reg_addr(4'd2, 8'h00), '0, '0, 1'b1);
    add_step(OP_WRITE, reg_addr(4'd2, 8'h00), 32'h1234, '0, 1'b1);
    add_step(OP_READ, reg_addr(REGION_SPI, 8'h0c), '0, '0, 1'b1);
    add_step(OP_READ, reg_addr(REGION_UART, 8'h08), '0, '0, 1'b1);

    repeat (2) @(posedge zynq_clk);
    @(negedge zynq_clk);
    rst = 1'b0;
    if (spi_csn !== 1'b1 || spi_sck !== 1'b0 || spi_sdo !== 1'b0) begin
      note_error($sformatf("spi lines after reset csn %b sck %b sdo %b", spi_csn, spi_sck,
                           spi_sdo));
    end

    run_steps();

    $display("steps run: %0d, errors: %0d", step_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
